// ==== build.f ====
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_bit_timer.sv
verilog/uart_rx_fsm.sv
verilog/uart_rx_shifter.sv
verilog/uart_tx_serializer.sv
verilog/uart_link.sv
sim/uart_link_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := uart_link_tb
FILELIST   := build.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/uart_link_tb.sv ====
`include "uart_config.svh"

module uart_link_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int BIT_CLKS       = `UART_BIT_CLKS;
	localparam int TIMEOUT_CYCLES = 8000;
	localparam int RANDOM_BYTES   = 15;

	logic               CLK_I;
	logic               RST_I;
	logic               rx_line;
	uart_pkg::rx_word_t rx_word;
	logic               rx_valid;
	logic               rx_ready;
	logic               rx_overrun;
	logic [7:0]         tx_data;
	logic               tx_valid;
	logic               tx_ready;
	logic               tx_line;

	logic       drv_line;
	logic       loopback;
	logic [7:0] expect_q[$]; // Bytes handed to the transmitter, oldest first
	integer     seed;
	int         error_count;
	int         test_count;
	int         cycle_count;

	assign rx_line = loopback ? tx_line : drv_line;

	uart_link uart_link_inst (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.rx_line    (rx_line),
		.rx_word    (rx_word),
		.rx_valid   (rx_valid),
		.rx_ready   (rx_ready),
		.rx_overrun (rx_overrun),
		.tx_data    (tx_data),
		.tx_valid   (tx_valid),
		.tx_ready   (tx_ready),
		.tx_line    (tx_line)
	);

	always #20 CLK_I = ~CLK_I;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
			error_count++;
		end
	endtask

	// Start bit, data LSB first, stop bit, then a short high gap
	task automatic send_frame(input logic [7:0] data, input logic stop_level);
		logic [9:0] frame;
		frame = {stop_level, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			drv_line = frame[i];
			repeat (BIT_CLKS) @(negedge CLK_I);
		end
		drv_line = 1'b1;
		repeat (2) @(negedge CLK_I);
	endtask

	task automatic wait_word(input int limit, output uart_pkg::rx_word_t word,
		output logic seen);
		int n;
		seen = 1'b0;
		word = '0;
		n = 0;
		while (!seen && n < limit) begin
			@(negedge CLK_I);
			n++;
			if (rx_valid) begin
				seen = 1'b1;
				word = rx_word;
			end
		end
	endtask

	task automatic send_and_expect(input logic [7:0] data, input logic stop_level);
		uart_pkg::rx_word_t word;
		logic seen;
		fork
			send_frame(data, stop_level);
			wait_word(11 * BIT_CLKS, word, seen); // Counted from the start edge
		join
		if (!seen) begin
			$display("No word received within 11 bit periods for byte 0x%0h", data);
			error_count++;
		end else begin
			check_value("rx_word.data", 32'(word.data), 32'(data));
			check_value("rx_word.frame_err", 32'(word.frame_err), 32'(!stop_level));
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, error_count - errors_before);
	endtask

	task automatic after_reset();
		int errs;
		errs = error_count;
		check_value("tx_line", 32'(tx_line), 32'd1);
		check_value("tx_ready", 32'(tx_ready), 32'd1);
		check_value("rx_valid", 32'(rx_valid), 32'd0);
		check_value("rx_overrun", 32'(rx_overrun), 32'd0);
		report_test("after_reset", errs);
	endtask

	task automatic clean_frames();
		int errs;
		errs = error_count;
		send_and_expect(8'h55, 1'b1);
		send_and_expect(8'hA3, 1'b1);
		send_and_expect(8'h00, 1'b1);
		report_test("clean_frames", errs);
	endtask

	task automatic framing_error();
		int errs;
		errs = error_count;
		send_and_expect(8'h3C, 1'b0);
		send_and_expect(8'hC6, 1'b1);
		report_test("framing_error", errs);
	endtask

	task automatic false_start();
		uart_pkg::rx_word_t word;
		logic seen;
		int errs;
		errs = error_count;
		drv_line = 1'b0;
		repeat (3) @(negedge CLK_I); // Well under half a bit
		drv_line = 1'b1;
		wait_word(20 * BIT_CLKS, word, seen);
		if (seen) begin
			$display("Short low pulse produced a word with data 0x%0h", word.data);
			error_count++;
		end
		send_and_expect(8'h96, 1'b1);
		report_test("false_start", errs);
	endtask

	task automatic overrun();
		int errs;
		errs = error_count;
		rx_ready = 1'b0;
		send_and_expect(8'h5A, 1'b1);
		send_frame(8'hE1, 1'b1);
		check_value("rx_valid", 32'(rx_valid), 32'd1);
		check_value("rx_word.data", 32'(rx_word.data), 32'h5A);
		check_value("rx_overrun", 32'(rx_overrun), 32'd1);
		rx_ready = 1'b1;
		@(negedge CLK_I);
		check_value("rx_valid", 32'(rx_valid), 32'd0);
		report_test("overrun", errs);
	endtask

	task automatic offer_random_bytes(input int count);
		logic [7:0] b;
		int waited;
		int busy;
		b = 8'($random(seed));
		for (int i = 0; i < count; i++) begin
			tx_data = b;
			tx_valid = 1'b1;
			waited = 0;
			while (!tx_ready && waited < 12 * BIT_CLKS) begin
				@(negedge CLK_I);
				waited++;
			end
			if (!tx_ready) begin
				$display("Transmitter never became ready for byte %0d", i);
				error_count++;
			end else begin
				expect_q.push_back(b);
				@(negedge CLK_I); // Transfer on the rising edge in between
				check_value("tx_ready", 32'(tx_ready), 32'd0);
				check_value("tx_line", 32'(tx_line), 32'd0);
				// Next byte stays offered while this frame goes out
				b = 8'($random(seed));
				tx_data = b;
				tx_valid = (i < count - 1);
				busy = 0;
				while (!tx_ready && busy < 12 * BIT_CLKS) begin
					busy++;
					@(negedge CLK_I);
				end
				if (busy < 10 * BIT_CLKS) begin
					$display("tx_ready came back after only %0d cycles for byte %0d", busy, i);
					error_count++;
				end
			end
		end
		tx_valid = 1'b0;
	endtask

	task automatic collect_bytes(input int count);
		uart_pkg::rx_word_t word;
		logic seen;
		logic [7:0] expected;
		for (int i = 0; i < count; i++) begin
			wait_word(12 * BIT_CLKS, word, seen);
			if (!seen) begin
				$display("Loopback byte %0d never arrived", i);
				error_count++;
			end else if (expect_q.size() == 0) begin
				$display("Received 0x%0h but no byte was sent", word.data);
				error_count++;
			end else begin
				expected = expect_q.pop_front();
				check_value("rx_word.data", 32'(word.data), 32'(expected));
				check_value("rx_word.frame_err", 32'(word.frame_err), 32'd0);
			end
		end
	endtask

	task automatic loopback_random();
		int errs;
		errs = error_count;
		loopback = 1'b1;
		fork
			offer_random_bytes(RANDOM_BYTES);
			collect_bytes(RANDOM_BYTES);
		join
		if (expect_q.size() != 0) begin
			$display("%0d sent bytes never came back", expect_q.size());
			error_count++;
		end
		loopback = 1'b0;
		report_test("loopback_random", errs);
	endtask

	initial begin
		CLK_I = 1'b0;
		RST_I = 1'b1;
		drv_line = 1'b1;
		loopback = 1'b0;
		rx_ready = 1'b1;
		tx_data = '0;
		tx_valid = 1'b0;
		seed = 89;
		error_count = 0;
		test_count = 0;
		repeat (16) @(negedge CLK_I);
		RST_I = 1'b0;

		after_reset();
		clean_frames();
		framing_error();
		false_start();
		overrun();
		loopback_random();

		$display("Tests run: %0d, errors: %0d", test_count, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Roughly twice the clocks all frames need
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge CLK_I);
			cycle_count++;
		end
		$display("Timeout: simulation ran for %0d clock cycles without finishing", cycle_count);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== verilog/uart_link.sv ====
module uart_link (
	input  logic               CLK_I,
	input  logic               RST_I,
	input  logic               rx_line,
	output uart_pkg::rx_word_t rx_word,
	output logic               rx_valid,
	input  logic               rx_ready,
	output logic               rx_overrun,
	input  logic [7:0]         tx_data,
	input  logic               tx_valid,
	output logic               tx_ready,
	output logic               tx_line
);

	uart_pkg::rx_sample_t rx_sample;

	uart_rx_fsm rx_fsm_inst (
		.CLK_I   (CLK_I),
		.RST_I   (RST_I),
		.rx_line (rx_line),
		.sample  (rx_sample)
	);

	uart_rx_shifter rx_shifter_inst (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.sample     (rx_sample),
		.rx_word    (rx_word),
		.rx_valid   (rx_valid),
		.rx_ready   (rx_ready),
		.rx_overrun (rx_overrun)
	);

	uart_tx_serializer tx_serializer_inst (
		.CLK_I    (CLK_I),
		.RST_I    (RST_I),
		.tx_data  (tx_data),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.tx_line  (tx_line)
	);

endmodule

// ==== verilog/uart_tx_serializer.sv ====
module uart_tx_serializer (
	input  logic       CLK_I,
	input  logic       RST_I,
	input  logic [7:0] tx_data,
	input  logic       tx_valid,
	output logic       tx_ready,
	output logic       tx_line
);

	localparam int FRAME_BITS = 10;
	localparam logic [3:0] LAST_BIT = 4'(FRAME_BITS - 1);

	logic                busy_q;
	logic [9:0]          frame_q;
	logic [3:0]          bit_cnt_q;
	logic                accept;
	uart_pkg::bit_tick_t tick;

	assign tx_ready = !busy_q;
	assign accept   = tx_valid && tx_ready;

	// Frame goes out from bit 0 and ones fill in from the top
	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			busy_q    <= 1'b0;
			frame_q   <= '1;
			bit_cnt_q <= '0;
		end else if (accept) begin
			busy_q    <= 1'b1;
			frame_q   <= {1'b1, tx_data, 1'b0}; // Stop, data, start
			bit_cnt_q <= '0;
		end else if (busy_q && tick.last) begin
			frame_q <= {1'b1, frame_q[9:1]};
			if (bit_cnt_q == LAST_BIT) begin
				busy_q    <= 1'b0;
				bit_cnt_q <= '0;
			end else begin
				bit_cnt_q <= bit_cnt_q + 1'b1;
			end
		end
	end

	assign tx_line = frame_q[0];

	uart_bit_timer tx_timer_inst (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.run   (busy_q),
		.tick  (tick)
	);

	a_idle_high: assert property (
		@(posedge CLK_I) disable iff (RST_I)
		tx_ready |-> tx_line
	) else $error("tx_line low while serializer idle");

	a_start_follows_accept: assert property (
		@(posedge CLK_I) disable iff (RST_I)
		accept |=> (!tx_line && !tx_ready)
	) else $error("start bit did not follow an accepted byte");

endmodule

// ==== verilog/uart_rx_shifter.sv ====
module uart_rx_shifter (
	input  logic                 CLK_I,
	input  logic                 RST_I,
	input  uart_pkg::rx_sample_t sample,
	output uart_pkg::rx_word_t   rx_word,
	output logic                 rx_valid,
	input  logic                 rx_ready,
	output logic                 rx_overrun
);

	logic [7:0] asm_q;
	logic       word_free;

	// LSB arrives first and ends up in bit 0 after eight shifts
	always_ff @(posedge CLK_I) begin
		if (sample.shift)
			asm_q <= {sample.bit_val, asm_q[7:1]};
	end

	assign word_free = !rx_valid;

	always_ff @(posedge CLK_I) begin
		if (sample.commit && word_free) begin
			rx_word.data      <= asm_q;
			rx_word.frame_err <= !sample.bit_val; // Stop bit must be high
		end
	end

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			rx_valid   <= 1'b0;
			rx_overrun <= 1'b0;
		end else begin
			if (sample.commit && word_free)
				rx_valid <= 1'b1;
			else if (rx_valid && rx_ready)
				rx_valid <= 1'b0;

			if (sample.commit && !word_free)
				rx_overrun <= 1'b1; // Sticky until reset
		end
	end

	a_word_held: assert property (
		@(posedge CLK_I) disable iff (RST_I)
		(rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_word))
	) else $error("received word changed before it was accepted");

endmodule

// ==== verilog/uart_rx_fsm.sv ====
`include "uart_config.svh"

module uart_rx_fsm (
	input  logic                 CLK_I,
	input  logic                 RST_I,
	input  logic                 rx_line,
	output uart_pkg::rx_sample_t sample
);

	localparam int SYNC_N = `UART_SYNC_STAGES;

	logic [SYNC_N-1:0]   sync_q;
	logic                line_s;
	logic                line_prev_q;
	logic                line_fall;
	uart_pkg::rx_state_e state_q;
	logic [2:0]          bit_idx_q;
	logic                timer_run;
	uart_pkg::bit_tick_t tick;

	// Line idles high, so the synchronizer resets to ones
	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			sync_q      <= '1;
			line_prev_q <= 1'b1;
		end else begin
			sync_q      <= {sync_q[SYNC_N-2:0], rx_line};
			line_prev_q <= line_s;
		end
	end

	assign line_s    = sync_q[SYNC_N-1];
	assign line_fall = line_prev_q && !line_s;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			state_q   <= uart_pkg::RX_IDLE;
			bit_idx_q <= '0;
		end else begin
			case (state_q)
				uart_pkg::RX_IDLE: begin
					if (line_fall)
						state_q <= uart_pkg::RX_START;
				end
				uart_pkg::RX_START: begin
					if (tick.mid && line_s) begin
						state_q <= uart_pkg::RX_IDLE; // Glitch, not a start bit
					end else if (tick.last) begin
						state_q   <= uart_pkg::RX_DATA;
						bit_idx_q <= '0;
					end
				end
				uart_pkg::RX_DATA: begin
					if (tick.last) begin
						bit_idx_q <= bit_idx_q + 1'b1;
						if (bit_idx_q == 3'd7)
							state_q <= uart_pkg::RX_STOP;
					end
				end
				uart_pkg::RX_STOP: begin
					// Leave at mid-bit to catch a back-to-back start edge
					if (tick.mid)
						state_q <= uart_pkg::RX_IDLE;
				end
				default: state_q <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	assign timer_run = (state_q != uart_pkg::RX_IDLE);

	uart_bit_timer rx_timer_inst (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.run   (timer_run),
		.tick  (tick)
	);

	assign sample.shift   = (state_q == uart_pkg::RX_DATA) && tick.mid;
	assign sample.commit  = (state_q == uart_pkg::RX_STOP) && tick.mid;
	assign sample.bit_val = line_s;

	// Sampled bit began inside RX_DATA
	a_shift_in_data: assert property (
		@(posedge CLK_I) disable iff (RST_I)
		sample.shift |-> ($past(state_q, `UART_BIT_CLKS / 2) == uart_pkg::RX_DATA)
	) else $error("shift issued outside RX_DATA");

endmodule

// ==== verilog/uart_bit_timer.sv ====
`include "uart_config.svh"

module uart_bit_timer (
	input  logic                CLK_I,
	input  logic                RST_I,
	input  logic                run,
	output uart_pkg::bit_tick_t tick
);

	localparam int CNT_W = $clog2(`UART_BIT_CLKS);
	localparam logic [CNT_W-1:0] MID_CNT  = CNT_W'(`UART_BIT_CLKS / 2);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`UART_BIT_CLKS - 1);

	logic [CNT_W-1:0] count_q;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			count_q <= '0;
		end else if (!run) begin
			count_q <= '0; // Restart on every new bit sequence
		end else if (count_q == LAST_CNT) begin
			count_q <= '0;
		end else begin
			count_q <= count_q + 1'b1;
		end
	end

	// Count may still be nonzero in the cycle run drops
	assign tick.mid  = run && (count_q == MID_CNT);
	assign tick.last = run && (count_q == LAST_CNT);

	a_ticks_exclusive: assert property (
		@(posedge CLK_I) disable iff (RST_I)
		!(tick.mid && tick.last)
	) else $error("bit timer raised mid and last in one cycle");

endmodule

// ==== verilog/uart_pkg.sv ====
package uart_pkg;

	// Receiver states
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0,
		RX_START = 2'd1,
		RX_DATA  = 2'd2,
		RX_STOP  = 2'd3
	} rx_state_e;

	// One-cycle pulses from a bit timer
	typedef struct packed {
		logic mid;  // Middle of the bit
		logic last; // Final clock of the bit
	} bit_tick_t;

	// Receive FSM to shifter
	typedef struct packed {
		logic shift;   // Take a data bit
		logic commit;  // Stop bit sampled
		logic bit_val; // Sampled line level
	} rx_sample_t;

	// Word handed to the outside
	typedef struct packed {
		logic [7:0] data;
		logic       frame_err;
	} rx_word_t;

endpackage

// ==== verilog/uart_config.svh ====
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Serial bit period in system clocks
// 25 MHz / 16 gives 1.5625 Mbaud
// Must be even and at least 4 so mid and last never coincide
`define UART_BIT_CLKS 16

// Flip-flops on the receive line before the FSM sees it
// At least 2
`define UART_SYNC_STAGES 2

`endif
